// File: src/branchPkg.sv
`default_nettype none

package branchPkg;

    // instruction, pc and register value
    typedef logic [31:0] word_t;

    // branch condition handed from decode to execute
    typedef logic [2:0] cond_t;

    localparam cond_t CondEq  = 3'd0;   // rs == rt
    localparam cond_t CondNe  = 3'd1;   // rs != rt
    localparam cond_t CondLez = 3'd2;   // rs <= 0
    localparam cond_t CondGtz = 3'd3;   // rs > 0
    localparam cond_t CondLtz = 3'd4;   // rs < 0
    localparam cond_t CondGez = 3'd5;   // rs >= 0
    // codes 6 and 7 are unused and resolve as not taken

    // primary opcodes, instr[31:26]
    localparam logic [5:0] OpRegimm = 6'b000001;
    localparam logic [5:0] OpBeq    = 6'b000100;
    localparam logic [5:0] OpBne    = 6'b000101;
    localparam logic [5:0] OpBlez   = 6'b000110;
    localparam logic [5:0] OpBgtz   = 6'b000111;

    // regimm selects the branch through the rt field, instr[20:16]
    localparam logic [4:0] RtBltz = 5'b00000;
    localparam logic [4:0] RtBgez = 5'b00001;

endpackage

`default_nettype wire

// File: src/branchPredict.sv
`default_nettype none

module branchPredict (
    input  logic             clk,
    input  logic             arstN_i,
    input  logic             stall_i,
    input  logic             validD_i,
    input  branchPkg::word_t instrD_i,
    input  branchPkg::word_t pcPlus4D_i,
    output logic             predRedirectD_o,
    output branchPkg::word_t predTargetD_o,
    output logic             branchE_o,
    output logic             predTakeE_o,
    output branchPkg::cond_t condE_o,
    output branchPkg::word_t targetE_o,
    output branchPkg::word_t fallThroughE_o
);
    import branchPkg::*;

    logic [5:0]  opcode;
    logic [4:0]  rtField;
    logic [15:0] imm;
    logic        isBranchD;
    cond_t       condD;
    word_t       offsetD;
    word_t       targetD;
    logic        predTakeD;

    assign opcode  = instrD_i[31:26];
    assign rtField = instrD_i[20:16];
    assign imm     = instrD_i[15:0];

    // branch decode and condition mapping
    always_comb begin
        isBranchD = 1'b1;
        condD     = CondEq;
        case (opcode)
            OpBeq:  condD = CondEq;
            OpBne:  condD = CondNe;
            OpBlez: condD = CondLez;
            OpBgtz: condD = CondGtz;
            OpRegimm: begin
                case (rtField)
                    RtBltz:  condD = CondLtz;
                    RtBgez:  condD = CondGez;
                    default: isBranchD = 1'b0;   // other regimm ops are not ours
                endcase
            end
            default: isBranchD = 1'b0;
        endcase
    end

    // sign extended word offset
    assign offsetD = {{14{imm[15]}}, imm, 2'b00};
    assign targetD = pcPlus4D_i + offsetD;

    // static rule: backward branches are taken
    assign predTakeD = isBranchD & imm[15];

    assign predRedirectD_o = validD_i & predTakeD;
    assign predTargetD_o   = targetD;

    // decode to execute register, control part
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            branchE_o <= 1'b0;
        end else if (!stall_i) begin
            branchE_o <= validD_i & isBranchD;
        end
    end

    // payload, only meaningful while branchE_o is set
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            predTakeE_o    <= predTakeD;
            condE_o        <= condD;
            targetE_o      <= targetD;
            fallThroughE_o <= pcPlus4D_i + 32'd4;   // skips the delay slot
        end
    end

endmodule

`default_nettype wire

// File: src/branchJudge.sv
`default_nettype none

module branchJudge (
    input  branchPkg::cond_t condE_i,
    input  branchPkg::word_t rsValueE_i,
    input  branchPkg::word_t rtValueE_i,
    output logic             actualTakeE_o
);
    import branchPkg::*;

    logic rsNeg;     // rs < 0 as signed
    logic rsZero;
    logic rsEqRt;

    assign rsNeg  = rsValueE_i[31];
    assign rsZero = (rsValueE_i == '0);
    assign rsEqRt = (rsValueE_i == rtValueE_i);

    // values arrive already forwarded from the execute muxes
    always_comb begin
        case (condE_i)
            CondEq:  actualTakeE_o = rsEqRt;
            CondNe:  actualTakeE_o = !rsEqRt;
            CondLez: actualTakeE_o = rsNeg | rsZero;
            CondGtz: actualTakeE_o = !rsNeg & !rsZero;
            CondLtz: actualTakeE_o = rsNeg;
            CondGez: actualTakeE_o = !rsNeg;
            default: actualTakeE_o = 1'b0;   // undefined code, never taken
        endcase
    end

endmodule

`default_nettype wire

// File: src/pcCtrl.sv
`default_nettype none

module pcCtrl #(
    parameter int CountWidth = 16
) (
    input  logic                  clk,
    input  logic                  arstN_i,
    input  logic                  stall_i,
    input  logic                  branchE_i,
    input  logic                  predTakeE_i,
    input  logic                  actualTakeE_i,
    input  branchPkg::word_t      targetE_i,
    input  branchPkg::word_t      fallThroughE_i,
    input  logic                  predRedirectD_i,
    input  branchPkg::word_t      predTargetD_i,
    output logic                  redirect_o,
    output branchPkg::word_t      redirectPc_o,
    output logic                  flush_o,
    output logic [CountWidth-1:0] mispredictCount_o
);

    localparam logic [CountWidth-1:0] CountMax = {CountWidth{1'b1}};

    logic mispredictE;
    logic countEn;

    // prediction disagrees with the resolved outcome
    assign mispredictE = branchE_i & (predTakeE_i ^ actualTakeE_i);

    // execute correction outranks the decode prediction
    always_comb begin
        if (mispredictE) begin
            if (actualTakeE_i) begin
                redirectPc_o = targetE_i;        // predicted not taken, was taken
            end else begin
                redirectPc_o = fallThroughE_i;   // back to pc+8, delay slot kept
            end
        end else if (predRedirectD_i) begin
            redirectPc_o = predTargetD_i;
        end else begin
            redirectPc_o = '0;                   // idle, no redirect
        end
    end

    assign redirect_o = mispredictE | predRedirectD_i;

    // drops the wrong-path fetch behind the delay slot
    assign flush_o = mispredictE;

    /* A stalled branch keeps mispredictE high for several cycles, but the
       counter only moves on the edge where the branch leaves execute. */
    assign countEn = mispredictE & !stall_i & (mispredictCount_o != CountMax);

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            mispredictCount_o <= '0;
        end else if (countEn) begin
            mispredictCount_o <= mispredictCount_o + 1'b1;   // saturates at max
        end
    end

endmodule

`default_nettype wire

// File: src/branchUnit.sv
`default_nettype none

module branchUnit #(
    parameter int CountWidth = 16
) (
    input  logic                  clk,
    input  logic                  arstN_i,
    input  logic                  stall_i,
    input  logic                  validD_i,
    input  branchPkg::word_t      instrD_i,
    input  branchPkg::word_t      pcPlus4D_i,
    input  branchPkg::word_t      rsValueE_i,
    input  branchPkg::word_t      rtValueE_i,
    output logic                  redirect_o,
    output branchPkg::word_t      redirectPc_o,
    output logic                  flush_o,
    output logic [CountWidth-1:0] mispredictCount_o
);
    import branchPkg::*;

    // decode side
    logic  predRedirectD;
    word_t predTargetD;

    // execute side
    logic  branchE;
    logic  predTakeE;
    logic  actualTakeE;
    cond_t condE;
    word_t targetE;
    word_t fallThroughE;

    branchPredict branchPredict0 (
        .clk             (clk),
        .arstN_i         (arstN_i),
        .stall_i         (stall_i),
        .validD_i        (validD_i),
        .instrD_i        (instrD_i),
        .pcPlus4D_i      (pcPlus4D_i),
        .predRedirectD_o (predRedirectD),
        .predTargetD_o   (predTargetD),
        .branchE_o       (branchE),
        .predTakeE_o     (predTakeE),
        .condE_o         (condE),
        .targetE_o       (targetE),
        .fallThroughE_o  (fallThroughE)
    );

    branchJudge branchJudge0 (
        .condE_i       (condE),
        .rsValueE_i    (rsValueE_i),
        .rtValueE_i    (rtValueE_i),
        .actualTakeE_o (actualTakeE)
    );

    pcCtrl #(
        .CountWidth (CountWidth)
    ) pcCtrl0 (
        .clk               (clk),
        .arstN_i           (arstN_i),
        .stall_i           (stall_i),
        .branchE_i         (branchE),
        .predTakeE_i       (predTakeE),
        .actualTakeE_i     (actualTakeE),
        .targetE_i         (targetE),
        .fallThroughE_i    (fallThroughE),
        .predRedirectD_i   (predRedirectD),
        .predTargetD_i     (predTargetD),
        .redirect_o        (redirect_o),
        .redirectPc_o      (redirectPc_o),
        .flush_o           (flush_o),
        .mispredictCount_o (mispredictCount_o)
    );

endmodule

`default_nettype wire

// File: verif/branchUnit_props.sv
`default_nettype none

module branchUnit_props #(
    parameter int CountWidth = 16
) (
    input logic                  clk,
    input logic                  arstN_i,
    input logic                  stall_i,
    input logic                  flush_o,
    input logic [CountWidth-1:0] mispredictCount_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // an unstalled flush below saturation is counted on the next edge
    flushIsCounted: assert property (@(posedge clk) disable iff (!arstN_i)
        (flush_o && !stall_i && mispredictCount_o != {CountWidth{1'b1}})
        |=> 32'(mispredictCount_o) == 32'($past(mispredictCount_o)) + 1)
        else $error("unstalled flush was not counted");

    countStepsByOne: assert property (@(posedge clk) disable iff (!arstN_i)
        $past(arstN_i) |-> (32'(mispredictCount_o) == 32'($past(mispredictCount_o)))
                        || (32'(mispredictCount_o) == 32'($past(mispredictCount_o)) + 1))
        else $error("mispredict counter jumped");

    // frozen while the pipeline stalls
    countHoldsInStall: assert property (@(posedge clk) disable iff (!arstN_i)
        ($past(arstN_i) && $past(stall_i)) |-> mispredictCount_o == $past(mispredictCount_o))
        else $error("mispredict counter moved during a stall");

endmodule

bind pcCtrl branchUnit_props #(.CountWidth(CountWidth)) props0 (
    .clk               (clk),
    .arstN_i           (arstN_i),
    .stall_i           (stall_i),
    .flush_o           (flush_o),
    .mispredictCount_o (mispredictCount_o)
);

`default_nettype wire

// File: verif/branchUnit_tb.sv
`default_nettype none

module branchUnit_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import branchPkg::*;

    localparam int CountW       = 3;      // small enough for the random run to saturate
    localparam int RandomCycles = 2000;
    localparam int TotalCycles  = 4 + 40 + RandomCycles + 100;

    logic               clk = 1'b0;
    logic               arstN = 1'b0;
    logic               stall = 1'b0;
    logic               validD = 1'b0;
    word_t              instrD = '0;
    word_t              pcPlus4D = '0;
    word_t              rsValue = '0;
    word_t              rtValue = '0;
    logic               redirect;
    word_t              redirectPc;
    logic               flush;
    logic [CountW-1:0]  mispredictCount;

    // reference execute entry and counter
    logic               mBranch = 1'b0;
    logic               mPredTake = 1'b0;
    cond_t              mCond = CondEq;
    word_t              mTarget = '0;
    word_t              mFall = '0;
    logic [CountW-1:0]  mCount = '0;
    logic [33:0]        expected;
    logic [4:0]         decoded;
    logic               mMiss;
    logic [31:0]        rngState = 32'h8139;
    string              testName = "reset";
    int                 errorCount = 0;

    branchUnit #(.CountWidth(CountW)) DUT (
        .clk               (clk),
        .arstN_i           (arstN),
        .stall_i           (stall),
        .validD_i          (validD),
        .instrD_i          (instrD),
        .pcPlus4D_i        (pcPlus4D),
        .rsValueE_i        (rsValue),
        .rtValueE_i        (rtValue),
        .redirect_o        (redirect),
        .redirectPc_o      (redirectPc),
        .flush_o           (flush),
        .mispredictCount_o (mispredictCount)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // {isBranch, predTake, cond}
    function automatic logic [4:0] decodeBranch(input word_t instr);
        logic [5:0] op;
        op = instr[31:26];
        if (op == OpBeq)  return {1'b1, instr[15], CondEq};
        if (op == OpBne)  return {1'b1, instr[15], CondNe};
        if (op == OpBlez) return {1'b1, instr[15], CondLez};
        if (op == OpBgtz) return {1'b1, instr[15], CondGtz};
        if (op == OpRegimm && instr[20:16] == RtBltz) return {1'b1, instr[15], CondLtz};
        if (op == OpRegimm && instr[20:16] == RtBgez) return {1'b1, instr[15], CondGez};
        return 5'b0;
    endfunction

    // pc+4 plus the signed word offset
    function automatic word_t branchTarget(input word_t pc4, input logic [15:0] imm);
        return pc4 + 32'($signed(imm)) * 32'd4;
    endfunction

    function automatic logic condHolds(input cond_t c, input word_t rs, input word_t rt);
        case (c)
            CondEq:  return rs == rt;
            CondNe:  return rs != rt;
            CondLez: return $signed(rs) <= 0;
            CondGtz: return $signed(rs) > 0;
            CondLtz: return $signed(rs) < 0;
            CondGez: return $signed(rs) >= 0;
            default: return 1'b0;
        endcase
    endfunction

    // {redirect, flush, pc} from the pending entry and the decode inputs
    function automatic logic [33:0] expectOutputs(input logic miss, input logic taken,
                                                  input logic v, input word_t instr,
                                                  input word_t pc4);
        logic [4:0] d;
        d = decodeBranch(instr);
        if (miss) return {2'b11, taken ? mTarget : mFall};
        if (v && d[4] && d[3]) return {2'b10, branchTarget(pc4, instr[15:0])};
        return {2'b00, 32'd0};
    endfunction

    task automatic checkValue(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errorCount++;
            $display("Mismatch %s %s expected %h actual %h", testName, what, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // compare mid cycle and step the model as the next edge will
    always @(negedge clk) begin
        if (!arstN) begin
            mBranch = 1'b0;
            mCount  = '0;
        end else begin
            mMiss = mBranch && (mPredTake != condHolds(mCond, rsValue, rtValue));
            expected = expectOutputs(mMiss, condHolds(mCond, rsValue, rtValue),
                                     validD, instrD, pcPlus4D);
            checkValue("redirect", 32'(expected[33]), 32'(redirect));
            checkValue("flush", 32'(expected[32]), 32'(flush));
            checkValue("count", 32'(mCount), 32'(mispredictCount));
            if (expected[33]) checkValue("redirectPc", expected[31:0], redirectPc);
            if (!stall) begin
                if (mMiss && mCount != {CountW{1'b1}}) mCount = mCount + 1'b1;
                decoded   = decodeBranch(instrD);
                mBranch   = validD && decoded[4];
                mPredTake = decoded[3];
                mCond     = decoded[2:0];
                mTarget   = branchTarget(pcPlus4D, instrD[15:0]);
                mFall     = pcPlus4D + 32'd4;
            end
        end
    end

    function automatic word_t makeInstr(input int kind, input logic [15:0] imm);
        case (kind)
            0: return {OpBeq, 5'd3, 5'd4, imm};
            1: return {OpBne, 5'd3, 5'd4, imm};
            2: return {OpBlez, 5'd3, 5'd0, imm};
            3: return {OpBgtz, 5'd3, 5'd0, imm};
            4: return {OpRegimm, 5'd3, RtBltz, imm};
            5: return {OpRegimm, 5'd3, RtBgez, imm};
            6: return {OpRegimm, 5'd3, 5'd2, imm};   // regimm op that is no branch
            default: return {6'b001001, 5'd3, 5'd4, imm};   // addiu
        endcase
    endfunction

    function automatic word_t pickValue(input logic [31:0] r);
        case (r[2:0])
            3'd0: return 32'h0000_0000;
            3'd1: return 32'h0000_0001;
            3'd2: return 32'hffff_ffff;
            3'd3: return 32'h8000_0000;
            3'd4: return 32'h7fff_ffff;
            default: return {r[31:3], 3'b0};
        endcase
    endfunction

    task automatic driveCycle(input logic v, input word_t instr, input word_t pc4,
                              input word_t rs, input word_t rt, input logic st);
        @(posedge clk);
        #1;
        validD   = v;
        instrD   = instr;
        pcPlus4D = pc4;
        rsValue  = rs;
        rtValue  = rt;
        stall    = st;
    endtask

    initial begin
        #(TotalCycles * 4);
        $display("Timeout: the run did not finish within %0d cycles", TotalCycles);
        $display("Errors found");
        $fatal(1);
    end

    initial begin
        word_t rs;
        word_t rt;
        repeat (4) @(posedge clk);
        #1 arstN = 1'b1;
        driveCycle(0, '0, '0, '0, '0, 0);
        testName = "decodePredict";
        driveCycle(1, makeInstr(0, 16'hfff0), 32'h0000_1004, 0, 1, 0);
        driveCycle(1, makeInstr(1, 16'h0010), 32'h0000_2004, 0, 0, 0);
        driveCycle(1, makeInstr(7, 16'hfff0), 32'h0000_3004, 0, 0, 0);
        testName = "lateTaken";
        driveCycle(1, makeInstr(0, 16'h0020), 32'h0000_4004, 0, 0, 0);
        driveCycle(0, '0, '0, 32'd5, 32'd5, 0);   // resolves taken and mispredicts
        testName = "lateNotTakenPriority";
        driveCycle(1, makeInstr(1, 16'hff00), 32'h0000_5004, 0, 0, 0);
        driveCycle(1, makeInstr(4, 16'hfffc), 32'h0000_6004, 32'd9, 32'd9, 0);
        driveCycle(0, '0, '0, 32'h8000_0000, 0, 0);
        testName = "stallHold";
        driveCycle(1, makeInstr(1, 16'h0004), 32'h0000_7004, 0, 0, 0);
        repeat (3) driveCycle(0, '0, '0, 32'd1, 32'd2, 1);
        driveCycle(0, '0, '0, 32'd1, 32'd2, 0);
        driveCycle(0, '0, '0, 0, 0, 0);
        testName = "random";
        for (int i = 0; i < RandomCycles; i++) begin
            rngState = lcgNext(rngState);
            rs = pickValue(rngState);
            rngState = lcgNext(rngState);
            rt = rngState[28] ? rs : pickValue(rngState);
            rngState = lcgNext(rngState);
            driveCycle(rngState[31:29] != 3'd0,
                       makeInstr(int'(rngState[27:25]),
                                 {{8{rngState[24]}}, rngState[23:16]}),
                       {16'h0040, rngState[15:2], 2'b00}, rs, rt,
                       rngState[1:0] == 2'd0);
        end
        driveCycle(0, '0, '0, 0, 0, 0);
        @(posedge clk);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
src/branchPkg.sv
src/branchPredict.sv
src/branchJudge.sv
src/pcCtrl.sv
src/branchUnit.sv
verif/branchUnit_props.sv
verif/branchUnit_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the branch unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module branchUnit_tb -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/VbranchUnit_tb > "$LOG" 2>&1
runStatus=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
    echo "simulation FAILED"
    exit 1
fi
if [ $runStatus -ne 0 ]; then
    echo "simulation exited with status $runStatus"
    exit 1
fi
echo "simulation passed"
exit 0
